/* len5_pkg.sv */
// ISA definitions for the cut-down instruction datapath
// Widths, major opcodes, fetch exception codes and fixed PCs
`default_nettype none

package len5_pkg;

  // Address and data width
  localparam int unsigned XLEN = 32;
  // No compressed instructions
  localparam int unsigned ILEN = 32;

  // PC after reset
  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0000;
  // Redirect target of any fetch exception
  localparam logic [XLEN-1:0] TRAP_PC = 32'h0000_0100;

  // RV32I major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_OPIMM  = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_OP     = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111
  } opcode_t;

  // Fetch exceptions
  typedef enum logic [1:0] {
    E_NONE           = 2'd0,
    E_I_MISALIGNED   = 2'd1,
    E_I_ACCESS_FAULT = 2'd2
  } except_code_t;

endpackage

`default_nettype wire

/* expipe_pkg.sv */
// Pipeline structures shared by front end, instruction queue and back end
// Also holds the queue and BTB sizes
`default_nettype none

package expipe_pkg;

  // Instruction queue size
  localparam int unsigned IQ_DEPTH   = 4;
  localparam int unsigned IQ_IDX_LEN = $clog2(IQ_DEPTH);

  // BTB index width, 16 entries
  localparam int unsigned BTB_BITS    = 4;
  localparam int unsigned BTB_ENTRIES = 2 ** BTB_BITS;
  // PC bits above index and byte offset
  localparam int unsigned BTB_TAG_LEN = len5_pkg::XLEN - BTB_BITS - 2;

  // Answer from the instruction cache
  typedef struct packed {
    logic [len5_pkg::ILEN-1:0] instruction;
    logic                      access_fault;
  } icache_out_t;

  // Fetch-time prediction
  typedef struct packed {
    logic [len5_pkg::XLEN-1:0] pc;
    logic [len5_pkg::XLEN-1:0] target;
    logic                      taken;
  } prediction_t;

  // Back end redirect, also used as BTB update
  typedef struct packed {
    logic                      valid;
    logic [len5_pkg::XLEN-1:0] pc;
    logic [len5_pkg::XLEN-1:0] target;
    logic                      taken;
    logic                      mispredict;
  } resolution_t;

  // One slot of the instruction queue
  typedef struct packed {
    logic [len5_pkg::ILEN-1:0] instruction;
    prediction_t               pred;
    logic                      except_raised;
    len5_pkg::except_code_t    except_code;
  } iq_entry_t;

endpackage

`default_nettype wire

/* front_end.sv */
// Fetch front end
// PC generation, direct-mapped BTB prediction and the I$ request/answer
// handshake; stale answers after a redirect are dropped by epoch
`default_nettype none

module front_end (
  input  wire logic                          clk_i,
  input  wire logic                          arst_n_i,
  // I$ request
  output logic        [len5_pkg::XLEN-1:0]   addr_o,
  output logic                               addr_valid_o,
  input  wire logic                          addr_ready_i,
  // I$ answer
  input  var  expipe_pkg::icache_out_t       data_i,
  input  wire logic                          data_valid_i,
  output logic                               data_ready_o,
  // To the instruction queue
  output logic                               issue_valid_o,
  input  wire logic                          issue_ready_i,
  output expipe_pkg::iq_entry_t              entry_o,
  // Redirect from the back end
  input  var  expipe_pkg::resolution_t       res_i
);

  import len5_pkg::*;
  import expipe_pkg::*;

  typedef enum logic [1:0] {FE_BOOT, FE_REQ, FE_WAIT, FE_HALT} fe_state_t;

  typedef struct packed {
    logic [BTB_TAG_LEN-1:0] tag;
    logic [XLEN-1:0]        target;
  } btb_entry_t;

  fe_state_t                  state_q, state_d;
  logic      [XLEN-1:0]       pc_q, pc_d;
  logic                       epoch_q, epoch_d;
  logic                       req_epoch_q, req_epoch_d;
  logic                       stale;
  logic                       misaligned;
  logic                       ans_fire;
  logic      [BTB_ENTRIES-1:0] btb_valid_q;
  btb_entry_t                 btb_q [BTB_ENTRIES];
  logic      [BTB_BITS-1:0]   btb_idx;
  logic      [BTB_BITS-1:0]   upd_idx;
  logic                       btb_hit;
  prediction_t                pred;

  // No C extension, so anything off a word boundary faults
  assign misaligned = pc_q[1:0] != 2'b00;
  // Answer belongs to a path that was redirected away
  assign stale      = req_epoch_q != epoch_q;

  // BTB lookup at the current PC
  assign btb_idx = pc_q[BTB_BITS+1:2];
  assign upd_idx = res_i.pc[BTB_BITS+1:2];
  assign btb_hit = btb_valid_q[btb_idx] &&
                   (btb_q[btb_idx].tag == pc_q[XLEN-1:BTB_BITS+2]);

  assign pred.pc     = pc_q;
  assign pred.taken  = btb_hit;
  assign pred.target = btb_hit ? btb_q[btb_idx].target : pc_q + XLEN'(4);

  // Misaligned PCs never reach the cache
  assign addr_o       = pc_q;
  assign addr_valid_o = (state_q == FE_REQ) && !misaligned;
  // Stale answers are always taken and thrown away
  assign data_ready_o = (state_q == FE_WAIT) && (stale || issue_ready_i);
  assign ans_fire     = data_valid_i && data_ready_o;
  // Push only when the queue takes it
  assign issue_valid_o = (ans_fire && !stale) ||
                         ((state_q == FE_REQ) && misaligned && issue_ready_i);

  // Queue entry, exception flags override the cache word
  always_comb begin
    entry_o.instruction   = data_i.instruction;
    entry_o.pred          = pred;
    entry_o.except_raised = 1'b0;
    entry_o.except_code   = E_NONE;
    if (misaligned) begin
      entry_o.instruction   = '0;
      entry_o.except_raised = 1'b1;
      entry_o.except_code   = E_I_MISALIGNED;
    end else if (data_i.access_fault) begin
      entry_o.except_raised = 1'b1;
      entry_o.except_code   = E_I_ACCESS_FAULT;
    end
  end

  // Next PC and fetch FSM
  always_comb begin
    state_d     = state_q;
    pc_d        = pc_q;
    epoch_d     = epoch_q;
    req_epoch_d = req_epoch_q;
    unique case (state_q)
      FE_BOOT: state_d = FE_REQ;
      FE_REQ: begin
        if (misaligned) begin
          // Fault entry goes out, then wait for the trap
          if (issue_ready_i) state_d = FE_HALT;
        end else if (addr_ready_i) begin
          state_d     = FE_WAIT;
          req_epoch_d = epoch_q;
        end
      end
      FE_WAIT: begin
        if (ans_fire && stale) begin
          state_d = FE_REQ;
        end else if (ans_fire) begin
          pc_d    = pred.target;
          state_d = data_i.access_fault ? FE_HALT : FE_REQ;
        end
      end
      // Parked until the back end redirects
      FE_HALT: state_d = FE_HALT;
      default: state_d = FE_BOOT;
    endcase
    // Redirect wins; an outstanding request is still waited for
    if (res_i.valid) begin
      pc_d    = res_i.target;
      epoch_d = ~epoch_q;
      if (state_d != FE_WAIT) state_d = FE_REQ;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= FE_BOOT;
      pc_q        <= BOOT_PC;
      epoch_q     <= 1'b0;
      req_epoch_q <= 1'b0;
      btb_valid_q <= '0;
    end else begin
      state_q     <= state_d;
      pc_q        <= pc_d;
      epoch_q     <= epoch_d;
      req_epoch_q <= req_epoch_d;
      // Taken outcome allocates, not-taken evicts
      if (res_i.valid && res_i.mispredict) btb_valid_q[upd_idx] <= res_i.taken;
    end
  end

  // BTB payload
  always_ff @(posedge clk_i) begin
    if (res_i.valid && res_i.mispredict && res_i.taken) begin
      btb_q[upd_idx].tag    <= res_i.pc[XLEN-1:BTB_BITS+2];
      btb_q[upd_idx].target <= res_i.target;
    end
  end

  // Request held until the cache takes it, unless redirected
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    addr_valid_o && !addr_ready_i && !res_i.valid |=> addr_valid_o && $stable(addr_o));

endmodule

`default_nettype wire

/* instr_queue.sv */
// Flushable instruction queue between fetch and the back end
// Circular buffer with head/tail pointers and an occupancy count
`default_nettype none

module instr_queue (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire logic                  flush_i,
  // Push side, from the front end
  input  wire logic                  push_i,
  input  var  expipe_pkg::iq_entry_t entry_i,
  output logic                       ready_o,
  // Pop side, to the back end
  output logic                       entry_valid_o,
  output expipe_pkg::iq_entry_t      entry_o,
  input  wire logic                  pop_i
);

  import expipe_pkg::*;

  iq_entry_t               mem_q [IQ_DEPTH];
  logic [IQ_IDX_LEN-1:0]   head_q;
  logic [IQ_IDX_LEN-1:0]   tail_q;
  logic [IQ_IDX_LEN:0]     count_q;
  logic                    full;
  logic                    empty;
  logic                    push_en;
  logic                    pop_en;

  // Wrap at the last slot, depth need not be a power of two
  function automatic logic [IQ_IDX_LEN-1:0] next_idx(input logic [IQ_IDX_LEN-1:0] idx);
    next_idx = (idx == IQ_IDX_LEN'(IQ_DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  assign full    = count_q == (IQ_IDX_LEN + 1)'(IQ_DEPTH);
  assign empty   = count_q == '0;
  assign push_en = push_i && !full;
  assign pop_en  = pop_i && !empty;

  assign ready_o       = !full;
  assign entry_valid_o = !empty;
  // Head slot read straight out
  assign entry_o       = mem_q[head_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      // Flush beats a push in the same cycle
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_en) tail_q <= next_idx(tail_q);
      if (pop_en) head_q <= next_idx(head_q);
      if (push_en && !pop_en) count_q <= count_q + 1'b1;
      else if (pop_en && !push_en) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) mem_q[tail_q] <= entry_i;
  end

  // Producer honours ready_o, consumer honours entry_valid_o
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> ready_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> entry_valid_o);

endmodule

`default_nettype wire

/* back_end.sv */
// Simplified back end
// Decodes opcodes, resolves branches with all registers reading zero,
// traps on fetch exceptions and commits in program order
`default_nettype none

module back_end (
  input  wire logic                          clk_i,
  input  wire logic                          arst_n_i,
  input  wire logic                          stall_i,
  // From the instruction queue
  input  wire logic                          entry_valid_i,
  input  var  expipe_pkg::iq_entry_t         entry_i,
  output logic                               pop_o,
  // Redirect to the front end
  output expipe_pkg::resolution_t            res_o,
  // Commit port
  output logic                               commit_valid_o,
  output logic        [len5_pkg::XLEN-1:0]   commit_pc_o,
  output logic        [len5_pkg::ILEN-1:0]   commit_instr_o,
  output logic                               except_raised_o,
  output len5_pkg::except_code_t             except_code_o
);

  import len5_pkg::*;
  import expipe_pkg::*;

  opcode_t           opcode;
  logic [2:0]        funct3;
  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   b_imm;
  logic [XLEN-1:0]   j_imm;
  logic              act_taken;
  logic [XLEN-1:0]   act_target;
  logic              mispredict;
  resolution_t       res_d;

  assign pc     = entry_i.pred.pc;
  assign opcode = opcode_t'(entry_i.instruction[6:0]);
  assign funct3 = entry_i.instruction[14:12];

  // B-type and J-type immediates
  assign b_imm = {{19{entry_i.instruction[31]}}, entry_i.instruction[31],
                  entry_i.instruction[7], entry_i.instruction[30:25],
                  entry_i.instruction[11:8], 1'b0};
  assign j_imm = {{11{entry_i.instruction[31]}}, entry_i.instruction[31],
                  entry_i.instruction[19:12], entry_i.instruction[20],
                  entry_i.instruction[30:21], 1'b0};

  // Nothing popped in the redirect cycle, queue is being flushed
  assign pop_o = entry_valid_i && !stall_i && !res_o.valid;

  // Actual outcome with rs1 == rs2 == 0
  always_comb begin
    act_taken  = 1'b0;
    act_target = pc + XLEN'(4);
    unique case (opcode)
      OP_BRANCH: begin
        // EQ, GE, GEU hold on equal operands; NE, LT, LTU never do
        act_taken = ~(funct3[2] ^ funct3[0]);
        if (act_taken) act_target = pc + b_imm;
      end
      OP_JAL: begin
        act_taken  = 1'b1;
        act_target = pc + j_imm;
      end
      // JALR, memory and ALU ops retire with no effect
      OP_JALR, OP_LOAD, OP_STORE, OP_OP, OP_OPIMM, OP_LUI: act_taken = 1'b0;
      default: act_taken = 1'b0;
    endcase
  end

  assign mispredict = (act_taken != entry_i.pred.taken) ||
                      (act_target != entry_i.pred.target);

  // Trap redirect takes priority over branch outcome
  always_comb begin
    res_d.valid      = pop_o && (entry_i.except_raised || mispredict);
    res_d.pc         = pc;
    res_d.target     = act_target;
    res_d.taken      = act_taken;
    res_d.mispredict = 1'b1;
    if (entry_i.except_raised) begin
      res_d.target = TRAP_PC;
      res_d.taken  = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_o           <= '0;
      commit_valid_o  <= 1'b0;
      except_raised_o <= 1'b0;
      except_code_o   <= E_NONE;
    end else begin
      res_o           <= res_d;
      commit_valid_o  <= pop_o;
      except_raised_o <= pop_o && entry_i.except_raised;
      except_code_o   <= (pop_o && entry_i.except_raised) ? entry_i.except_code : E_NONE;
    end
  end

  // Commit payload
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      commit_pc_o    <= pc;
      commit_instr_o <= entry_i.instruction;
    end
  end

  // Redirect is a one-cycle pulse and leaves the queue flushed behind it
  a_res_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res_o.valid |=> !res_o.valid && !entry_valid_i);

endmodule

`default_nettype wire

/* data_path.sv */
// Instruction datapath top
// Front end feeds the instruction queue, back end drains it and redirects
`default_nettype none

module data_path (
  input  wire logic                          clk_i,
  input  wire logic                          arst_n_i,
  input  wire logic                          stall_i,
  // I$ ports
  output logic        [len5_pkg::XLEN-1:0]   addr_o,
  output logic                               addr_valid_o,
  input  wire logic                          addr_ready_i,
  input  var  expipe_pkg::icache_out_t       data_i,
  input  wire logic                          data_valid_i,
  output logic                               data_ready_o,
  // Commit
  output logic                               commit_valid_o,
  output logic        [len5_pkg::XLEN-1:0]   commit_pc_o,
  output logic        [len5_pkg::ILEN-1:0]   commit_instr_o,
  output logic                               except_raised_o,
  output len5_pkg::except_code_t             except_code_o,
  output logic                               mispredict_o
);

  import expipe_pkg::*;

  logic        issue_valid;
  logic        issue_ready;
  iq_entry_t   fe_entry;
  iq_entry_t   iq_entry;
  logic        iq_valid;
  logic        pop;
  resolution_t res;

  // Traps also carry the mispredict bit
  assign mispredict_o = res.valid && res.mispredict;

  front_end u_front_end (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .addr_o        (addr_o),
    .addr_valid_o  (addr_valid_o),
    .addr_ready_i  (addr_ready_i),
    .data_i        (data_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o),
    .issue_valid_o (issue_valid),
    .issue_ready_i (issue_ready),
    .entry_o       (fe_entry),
    .res_i         (res)
  );

  // Any redirect flushes the queue
  instr_queue u_instr_queue (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (res.valid),
    .push_i        (issue_valid),
    .entry_i       (fe_entry),
    .ready_o       (issue_ready),
    .entry_valid_o (iq_valid),
    .entry_o       (iq_entry),
    .pop_i         (pop)
  );

  back_end u_back_end (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .stall_i         (stall_i),
    .entry_valid_i   (iq_valid),
    .entry_i         (iq_entry),
    .pop_o           (pop),
    .res_o           (res),
    .commit_valid_o  (commit_valid_o),
    .commit_pc_o     (commit_pc_o),
    .commit_instr_o  (commit_instr_o),
    .except_raised_o (except_raised_o),
    .except_code_o   (except_code_o)
  );

endmodule

`default_nettype wire

/* tb_data_path.sv */
// Testbench for the instruction datapath
// Behavioral I$ with random delays, reference commit model and
// concurrent checks on every commit
`default_nettype none

module tb_data_path;

  import len5_pkg::*;
  import expipe_pkg::*;

  localparam int          N_EXP     = 14;
  // Reference runs a few entries past the last awaited commit
  localparam int          N_REF     = N_EXP + 4;
  localparam int          TIMEOUT   = 40 * N_EXP;
  localparam int          DRIVE_DLY = 2;
  localparam logic [31:0] JAL_PC    = 32'h0000_0018;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   stall_i;
  logic [XLEN-1:0]        addr_o;
  logic                   addr_valid_o;
  logic                   addr_ready_i = 1'b0;
  icache_out_t            data_i = '0;
  logic                   data_valid_i = 1'b0;
  logic                   data_ready_o;
  logic                   commit_valid_o;
  logic [XLEN-1:0]        commit_pc_o;
  logic [ILEN-1:0]        commit_instr_o;
  logic                   except_raised_o;
  except_code_t           except_code_o;
  logic                   mispredict_o;

  // Cache model state
  integer                 seed = 32'h2db410df;
  logic                   has_req;
  logic [XLEN-1:0]        req_addr;
  logic                   req_fault;
  logic [1:0]             wait_cnt;
  logic                   jal_seen;
  logic [31:0]            rnd;

  // Expected commit stream
  logic [XLEN-1:0]        exp_pc    [N_REF];
  logic [ILEN-1:0]        exp_instr [N_REF];
  logic                   exp_exc   [N_REF];
  logic                   exp_misp  [N_REF];
  int                     commit_idx;
  int                     cycles;
  logic [XLEN-1:0]        cur_pc;
  logic [ILEN-1:0]        cur_instr;
  logic                   cur_exc;
  logic                   cur_misp;

  data_path DUT (.*);

  // Program image, unused words hold ALU ops tagged with their address
  function automatic logic [31:0] instr_at(input logic [31:0] addr);
    case (addr)
      32'h00:  instr_at = 32'h0010_0093;  // addi x1, x0, 1
      32'h04:  instr_at = 32'h0020_0113;  // addi x2, x0, 2
      32'h08:  instr_at = 32'h0000_0463;  // beq x0, x0, +8
      32'h0C:  instr_at = 32'h0030_0193;  // skipped by the beq
      32'h10:  instr_at = 32'h0000_1463;  // bne x0, x0, +8
      32'h14:  instr_at = 32'h0040_0213;
      32'h18:  instr_at = 32'hFF1F_F06F;  // jal x0, -16
      default: instr_at = {addr[26:2], 7'b0010011};
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("Something failed");
    $fatal(1);
  endtask

  // Clock
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Reference model: every register reads zero, JAL at its second visit faults
  initial begin : build_expected
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] tgt;
    logic        taken;
    int          jal_visits;
    bit          btb [logic [31:0]];
    pc         = BOOT_PC;
    jal_visits = 0;
    for (int i = 0; i < N_REF; i++) begin
      w            = instr_at(pc);
      exp_pc[i]    = pc;
      exp_instr[i] = w;
      exp_exc[i]   = 1'b0;
      if (pc == JAL_PC && jal_visits == 1) begin
        exp_exc[i]  = 1'b1;
        exp_misp[i] = 1'b1;
        pc          = TRAP_PC;
      end else begin
        taken = 1'b0;
        tgt   = pc + 32'd4;
        if (w[6:0] == 7'b1100011) begin
          // Equal operands satisfy EQ, GE and GEU only
          taken = (w[14:12] == 3'b000) || (w[14:12] == 3'b101) || (w[14:12] == 3'b111);
          if (taken)
            tgt = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end else if (w[6:0] == 7'b1101111) begin
          taken = 1'b1;
          tgt   = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        // Cold BTB misses a taken branch once, then predicts it
        exp_misp[i] = taken ? !btb.exists(pc) : btb.exists(pc);
        if (taken)
          btb[pc] = 1'b1;
        else if (btb.exists(pc))
          btb.delete(pc);
        if (pc == JAL_PC)
          jal_visits++;
        pc = tgt;
      end
    end
  end

  // Behavioral I$, an answer is held until the front end takes it
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      has_req      = 1'b0;
      req_addr     = '0;
      req_fault    = 1'b0;
      wait_cnt     = '0;
      jal_seen     = 1'b0;
      addr_ready_i = 1'b0;
      data_valid_i = 1'b0;
      data_i       = '0;
    end else begin
      if (commit_valid_o && commit_pc_o == JAL_PC)
        jal_seen = 1'b1;
      if (data_valid_i && data_ready_o)
        has_req = 1'b0;
      if (addr_valid_o && addr_ready_i) begin
        has_req   = 1'b1;
        req_addr  = addr_o;
        // Second pass over the JAL hits a bad line
        req_fault = (addr_o == JAL_PC) && jal_seen;
        rnd       = $random(seed);
        wait_cnt  = rnd[1:0];
      end
      #DRIVE_DLY;
      rnd          = $random(seed);
      addr_ready_i = !has_req && rnd[0];
      if (has_req && wait_cnt == 2'd0) begin
        data_valid_i       = 1'b1;
        data_i.instruction = instr_at(req_addr);
        data_i.access_fault = req_fault;
      end else begin
        data_valid_i = 1'b0;
        if (has_req && wait_cnt != 2'd0)
          wait_cnt = wait_cnt - 2'd1;
      end
    end
  end

  // Commit counter and cycle limit
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      commit_idx <= 0;
      cycles     <= 0;
    end else begin
      cycles <= cycles + 1;
      if (commit_valid_o)
        commit_idx <= commit_idx + 1;
      if (cycles >= TIMEOUT) begin
        $display("timeout: only %0d of %0d commits seen", commit_idx, N_EXP);
        $display("Something failed");
        $fatal(1);
      end
    end
  end

  assign cur_pc    = (commit_idx < N_REF) ? exp_pc[commit_idx] : '0;
  assign cur_instr = (commit_idx < N_REF) ? exp_instr[commit_idx] : '0;
  assign cur_exc   = (commit_idx < N_REF) ? exp_exc[commit_idx] : 1'b0;
  assign cur_misp  = (commit_idx < N_REF) ? exp_misp[commit_idx] : 1'b0;

  a_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_valid_o |-> commit_idx < N_REF)
    else abort_run("commit seen beyond the end of the reference sequence");
  a_pc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_valid_o |-> commit_pc_o == cur_pc)
    else report_mismatch("commit_pc_o", $sampled(cur_pc), $sampled(commit_pc_o));
  a_instr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_valid_o |-> commit_instr_o == cur_instr)
    else report_mismatch("commit_instr_o", $sampled(cur_instr), $sampled(commit_instr_o));
  a_exc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_valid_o |-> except_raised_o == cur_exc)
    else report_mismatch("except_raised_o", 32'($sampled(cur_exc)),
                         32'($sampled(except_raised_o)));
  a_code: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_valid_o && cur_exc |-> except_code_o == E_I_ACCESS_FAULT)
    else report_mismatch("except_code_o", 32'(E_I_ACCESS_FAULT),
                         32'($sampled(except_code_o)));
  a_misp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_valid_o |-> mispredict_o == cur_misp)
    else report_mismatch("mispredict_o", 32'($sampled(cur_misp)),
                         32'($sampled(mispredict_o)));
  // Held back end retires nothing
  a_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_i |=> !commit_valid_o)
    else report_mismatch("commit_valid_o", 32'd0, 32'($sampled(commit_valid_o)));

  // Reset, one long stall early in the run, then wait for all commits
  initial begin
    arst_n_i = 1'b0;
    stall_i  = 1'b0;
    repeat (10) @(posedge clk_i);
    #DRIVE_DLY;
    arst_n_i = 1'b1;
    while (commit_idx < 3) @(posedge clk_i);
    #DRIVE_DLY;
    stall_i = 1'b1;
    repeat (40) @(posedge clk_i);
    #DRIVE_DLY;
    stall_i = 1'b0;
    while (commit_idx < N_EXP) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
len5_pkg.sv
expipe_pkg.sv
front_end.sv
instr_queue.sv
back_end.sv
data_path.sv
tb_data_path.sv

/* Makefile */
# Verilator build for the instruction datapath

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_data_path
RTL_TOP   ?= data_path
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		len5_pkg.sv expipe_pkg.sv front_end.sv instr_queue.sv back_end.sv data_path.sv
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
